// File: include/decode_defines.svh
// ====================
// Sizing macros for the decode stage
// IN_DEPTH must stay a power of two because the queue pointers wrap
// by overflow, and the fetch line is always LINE_WORDS whole words
// ====================
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Fetch line geometry
`define LINE_WORDS 4
`define WORD_BITS 32
`define LINE_BITS 128

// Input queue depth, equal to the credits the fetch side starts with
`define IN_DEPTH 2

// Credits granted by the rename stage after reset
`define OUT_CREDITS 4

// Registers from this number upward belong to supervisor mode
`define PRIV_REG_BASE 24

`endif

// File: source/isa_pkg.sv
// ====================
// Instruction set encoding for the load/store core
// Only the integer, memory and compare-branch opcodes exist here
// ====================
package isa_pkg;

	// Privilege level that the fetch unit tags on every line
	typedef enum logic {
		MODE_USER  = 1'b0,
		MODE_SUPER = 1'b1
	} op_mode_t;

	// Major opcodes, low seven bits of every instruction word
	typedef enum logic [6:0] {
		OP_NOP   = 7'h00,
		OP_ADD   = 7'h01,
		OP_AND   = 7'h02,
		OP_OR    = 7'h03,
		OP_MUL   = 7'h04,
		OP_DIV   = 7'h05,
		// Add with a constant held elsewhere in the line
		OP_ADDC  = 7'h06,
		OP_LOAD  = 7'h07,
		// Load whose address constant is held elsewhere in the line
		OP_LOADC = 7'h08,
		OP_STORE = 7'h09,
		OP_BEQ   = 7'h0a
	} opcode_t;

	// Register form, up to three sources and one destination
	typedef struct packed {
		logic [4:0] fn;
		logic [4:0] rs3;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [4:0] rd;
		opcode_t    opcode;
	} r_fmt_t;

	// Constant form, cpos names the line word that holds the constant
	// and cwide extends it into word cpos+1
	typedef struct packed {
		logic [11:0] spare;
		logic        cwide;
		logic [1:0]  cpos;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_t     opcode;
	} c_fmt_t;

	// The same word seen through either format
	// OP_ADDC and OP_LOADC go through c, everything else through r
	typedef union packed {
		r_fmt_t r;
		c_fmt_t c;
	} instr_word_u;

endpackage

// File: source/decode_pkg.sv
// ====================
// Bundles passed between fetch, decode and rename
// Field order inside the structs is part of the interface
// ====================
`include "decode_defines.svh"

package decode_pkg;

	// Fault reported with a decoded instruction, FLT_NONE must stay zero
	typedef enum logic [1:0] {
		FLT_NONE     = 2'd0,
		FLT_BADREG   = 2'd1,
		FLT_BADCONST = 2'd2,
		FLT_BADOP    = 2'd3
	} fault_t;

	// One fetch line plus the word index of the instruction to decode
	typedef struct packed {
		logic [`LINE_BITS-1:0] line;
		logic [1:0]            slot;
		isa_pkg::op_mode_t     mode;
		// Reserved, the fetch unit drives zero
		logic [1:0]            spare;
	} fetch_item_t;

	// Everything rename needs to know about one instruction
	typedef struct packed {
		isa_pkg::instr_word_u     instr;
		logic [4:0]               rd;
		logic [4:0]               rs1;
		logic [4:0]               rs2;
		logic [4:0]               rs3;
		logic                     rdz;
		logic                     rs1z;
		logic                     rs2z;
		logic                     rs3z;
		logic                     alu;
		logic                     mul;
		logic                     div;
		logic                     load;
		logic                     store;
		logic                     branch;
		logic                     nop;
		logic                     mem;
		logic                     has_imm;
		logic [2*`WORD_BITS-1:0]  imm;
		logic [`LINE_WORDS-1:0]   nop_mask;
		fault_t                   cause;
	} decode_bus_t;

endpackage

// File: source/decode_const.sv
// ====================
// Constant extraction from the fetch line
// A 64-bit constant is stored low word first in cpos and cpos+1
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_const (
	input  isa_pkg::instr_word_u       instr,
	input  logic [`LINE_BITS-1:0]      line,
	input  logic [1:0]                 slot,
	output logic                       has_imm,
	output logic [2*`WORD_BITS-1:0]    imm,
	output logic [`LINE_WORDS-1:0]     nop_mask,
	output logic                       fault
);

	logic                   is_const;
	logic [1:0]             lo_pos;
	logic [1:0]             hi_pos;
	logic                   wide;
	logic [`WORD_BITS-1:0]  lo_word;
	logic [`WORD_BITS-1:0]  hi_word;

	// Only the two constant opcodes carry a constant, and for them
	// the word is read through the constant view
	assign is_const = (instr.c.opcode == isa_pkg::OP_ADDC) ||
		(instr.c.opcode == isa_pkg::OP_LOADC);
	assign has_imm = is_const;

	assign lo_pos = instr.c.cpos;
	// Wraps to 0 for cpos 3, which is caught as a fault below
	assign hi_pos = instr.c.cpos + 2'd1;
	assign wide   = instr.c.cwide;

	assign lo_word = line[lo_pos*`WORD_BITS +: `WORD_BITS];
	assign hi_word = line[hi_pos*`WORD_BITS +: `WORD_BITS];

	// ====================
	// Placement checks
	// ====================
	// The constant may not overlap the instruction itself, and a wide
	// constant starting at the last word would leave the line
	always_comb begin
		fault = 1'b0;
		if (is_const) begin
			if (lo_pos == slot)
				fault = 1'b1;
			if (wide && (lo_pos == 2'd3))
				fault = 1'b1;
			if (wide && (hi_pos == slot))
				fault = 1'b1;
		end
	end

	// ====================
	// Value and no-op mask
	// ====================
	always_comb begin
		imm      = '0;
		nop_mask = '0;
		if (is_const && !fault) begin
			// Narrow constants are zero extended
			if (wide)
				imm = {hi_word, lo_word};
			else
				imm = {{`WORD_BITS{1'b0}}, lo_word};
			// Fetch must skip the constant words as instructions
			nop_mask[lo_pos] = 1'b1;
			if (wide)
				nop_mask[hi_pos] = 1'b1;
		end
	end

endmodule

// File: source/decode_regs.sv
// ====================
// Register specifier decode and privilege check
// Constant-form words have no rs2 or rs3 and report them as register 0
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_regs (
	input  isa_pkg::instr_word_u  instr,
	input  isa_pkg::op_mode_t     mode,
	input  logic                  has_imm,
	output logic [4:0]            rd,
	output logic [4:0]            rs1,
	output logic [4:0]            rs2,
	output logic [4:0]            rs3,
	output logic                  rdz,
	output logic                  rs1z,
	output logic                  rs2z,
	output logic                  rs3z,
	output logic                  fault
);

	logic rd_priv;
	logic rs1_priv;
	logic rs2_priv;
	logic rs3_priv;

	// rd and rs1 sit at the same bits in both formats
	assign rd  = instr.r.rd;
	assign rs1 = instr.r.rs1;
	// Constant-form bits above rs1 are cpos and cwide, not registers
	assign rs2 = has_imm ? 5'd0 : instr.r.rs2;
	assign rs3 = has_imm ? 5'd0 : instr.r.rs3;

	assign rdz  = (rd  == 5'd0);
	assign rs1z = (rs1 == 5'd0);
	assign rs2z = (rs2 == 5'd0);
	assign rs3z = (rs3 == 5'd0);

	// Upper registers are reserved for supervisor code
	assign rd_priv  = (rd  >= 5'(`PRIV_REG_BASE));
	assign rs1_priv = (rs1 >= 5'(`PRIV_REG_BASE));
	assign rs2_priv = (rs2 >= 5'(`PRIV_REG_BASE));
	assign rs3_priv = (rs3 >= 5'(`PRIV_REG_BASE));

	// Unused specifiers are already forced to 0 and never trip the check
	assign fault = (mode == isa_pkg::MODE_USER) &&
		(rd_priv || rs1_priv || rs2_priv || rs3_priv);

endmodule

// File: source/decode_class.sv
// ====================
// Operation class decode
// Every opcode lands in exactly one class, unknown ones become nop
// ====================
`timescale 1ns/1ns

module decode_class (
	input  isa_pkg::opcode_t  opcode,
	output logic              alu,
	output logic              mul,
	output logic              div,
	output logic              load,
	output logic              store,
	output logic              branch,
	output logic              nop,
	output logic              mem,
	output logic              fault
);

	always_comb begin
		alu    = 1'b0;
		mul    = 1'b0;
		div    = 1'b0;
		load   = 1'b0;
		store  = 1'b0;
		branch = 1'b0;
		nop    = 1'b0;
		fault  = 1'b0;
		case (opcode)
			// Single cycle integer ops, the constant add included
			isa_pkg::OP_ADD,
			isa_pkg::OP_AND,
			isa_pkg::OP_OR,
			isa_pkg::OP_ADDC:
				alu = 1'b1;
			isa_pkg::OP_MUL:
				mul = 1'b1;
			isa_pkg::OP_DIV:
				div = 1'b1;
			// Both load forms go to the load unit
			isa_pkg::OP_LOAD,
			isa_pkg::OP_LOADC:
				load = 1'b1;
			isa_pkg::OP_STORE:
				store = 1'b1;
			isa_pkg::OP_BEQ:
				branch = 1'b1;
			isa_pkg::OP_NOP:
				nop = 1'b1;
			default: begin
				// Undefined encoding, pass it on harmlessly and flag it
				nop   = 1'b1;
				fault = 1'b1;
			end
		endcase
	end

	// Memory ops share the address path in rename
	assign mem = load | store;

endmodule

// File: source/instr_decoder.sv
// ====================
// Instruction decoder with one output register
// Sub-decoders are combinational, the bus updates only when en is high
// Faulted instructions are passed on with their decoded class
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module instr_decoder (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      en,
	input  decode_pkg::fetch_item_t   item,
	output logic                      out_valid,
	output decode_pkg::decode_bus_t   dbo
);

	isa_pkg::instr_word_u     instr;
	decode_pkg::decode_bus_t  db;
	logic                     const_fault;
	logic                     reg_fault;
	logic                     op_fault;

	// Pick the instruction word addressed by the slot
	assign instr    = item.line[item.slot*`WORD_BITS +: `WORD_BITS];
	assign db.instr = instr;

	decode_const u_const (
		.instr    (instr),
		.line     (item.line),
		.slot     (item.slot),
		.has_imm  (db.has_imm),
		.imm      (db.imm),
		.nop_mask (db.nop_mask),
		.fault    (const_fault)
	);

	// Constant-form words are recognised by has_imm from the constant decoder
	decode_regs u_regs (
		.instr   (instr),
		.mode    (item.mode),
		.has_imm (db.has_imm),
		.rd      (db.rd),
		.rs1     (db.rs1),
		.rs2     (db.rs2),
		.rs3     (db.rs3),
		.rdz     (db.rdz),
		.rs1z    (db.rs1z),
		.rs2z    (db.rs2z),
		.rs3z    (db.rs3z),
		.fault   (reg_fault)
	);

	decode_class u_class (
		.opcode (instr.r.opcode),
		.alu    (db.alu),
		.mul    (db.mul),
		.div    (db.div),
		.load   (db.load),
		.store  (db.store),
		.branch (db.branch),
		.nop    (db.nop),
		.mem    (db.mem),
		.fault  (op_fault)
	);

	// An unknown opcode makes the other checks meaningless, so it wins
	assign db.cause = op_fault  ? decode_pkg::FLT_BADOP :
		reg_fault   ? decode_pkg::FLT_BADREG :
		const_fault ? decode_pkg::FLT_BADCONST : decode_pkg::FLT_NONE;

	// ====================
	// Output register
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			// Idle bus looks like a nop writing register 0
			dbo       <= '0;
			dbo.nop   <= 1'b1;
			dbo.rdz   <= 1'b1;
			dbo.cause <= decode_pkg::FLT_NONE;
		end else begin
			out_valid <= en;
			if (en)
				dbo <= db;
		end
	end

endmodule

// File: source/decode_stage.sv
// ====================
// Decode stage top with credit flow control on both sides
// The sender must hold a credit before asserting in_valid, items are
// never refused and leave in arrival order
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_stage (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      in_valid,
	input  decode_pkg::fetch_item_t   in_item,
	output logic                      in_credit,
	output logic                      out_valid,
	output decode_pkg::decode_bus_t   out_bus,
	input  logic                      out_credit
);

	decode_pkg::fetch_item_t              q_mem [`IN_DEPTH];
	logic [$clog2(`IN_DEPTH)-1:0]         wr_ptr;
	logic [$clog2(`IN_DEPTH)-1:0]         rd_ptr;
	logic [$clog2(`IN_DEPTH+1)-1:0]       q_count;
	logic [$clog2(`OUT_CREDITS+1)-1:0]    out_cred;
	logic                                 dec_en;

	// Decode one item whenever there is one and rename can take it
	assign dec_en = (q_count != '0) && (out_cred != '0);

	// ====================
	// Input queue
	// ====================
	// Storage holds payload only, validity is tracked by q_count
	always_ff @(posedge clk) begin
		if (in_valid)
			q_mem[wr_ptr] <= in_item;
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (dec_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({in_valid, dec_en})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	// Every pop frees one entry, handed back to fetch a cycle later
	always_ff @(posedge clk) begin
		if (rst)
			in_credit <= 1'b0;
		else
			in_credit <= dec_en;
	end

	// ====================
	// Output credits
	// ====================
	// A returned credit and a spent one in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			out_cred <= ($bits(out_cred))'(`OUT_CREDITS);
		end else begin
			case ({out_credit, dec_en})
				2'b10:   out_cred <= out_cred + 1'b1;
				2'b01:   out_cred <= out_cred - 1'b1;
				default: out_cred <= out_cred;
			endcase
		end
	end

	// Queue head goes straight into the decoder
	instr_decoder u_decoder (
		.clk       (clk),
		.rst       (rst),
		.en        (dec_en),
		.item      (q_mem[rd_ptr]),
		.out_valid (out_valid),
		.dbo       (out_bus)
	);

endmodule

// File: tb/decode_assertions.sv
// ====================
// Protocol checks bound into decode_stage
// q_count and out_cred must match the counter widths inside the stage
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_assertions (
	input logic                               clk,
	input logic                               rst,
	input logic                               in_credit,
	input logic                               out_valid,
	input decode_pkg::decode_bus_t            out_bus,
	input logic [$clog2(`IN_DEPTH+1)-1:0]     q_count,
	input logic [$clog2(`OUT_CREDITS+1)-1:0]  out_cred
);

	int errors = 0;

	// The sender may never push past the queue depth
	queue_bound: assert property (@(posedge clk) disable iff (rst) q_count <= `IN_DEPTH)
		else begin
			$error("input queue holds more than IN_DEPTH items");
			errors++;
		end

	// Returned credits can only refill what was granted at reset
	credit_bound: assert property (@(posedge clk) disable iff (rst) out_cred <= `OUT_CREDITS)
		else begin
			$error("output credit counter above OUT_CREDITS");
			errors++;
		end

	// A bus is only sent when a credit was held in the decode cycle
	spend_credit: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(out_cred) != '0)
		else begin
			$error("out_valid raised without an output credit");
			errors++;
		end

	// Rename must never see X or Z on a valid bus
	bus_known: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_bus))
		else begin
			$error("out_bus has unknown bits while out_valid is high");
			errors++;
		end

	// Both handshake outputs come out of reset idle
	reset_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !in_credit)
		else begin
			$error("out_valid or in_credit high right after reset");
			errors++;
		end

endmodule

// File: tb/tb_decode_stage.sv
// ====================
// Testbench for decode_stage
// Expected buses come from a model of the decode rules and are checked
// in arrival order while the bound assertions check the protocol
// ====================
`timescale 1ns/1ns
`include "decode_defines.svh"

module tb_decode_stage;

	localparam int OP_OUT_CREDITS = `OUT_CREDITS;
	localparam int TIMEOUT = 200;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic in_credit;
	logic out_valid;
	logic out_credit;
	logic hold;
	decode_pkg::fetch_item_t in_item;
	decode_pkg::decode_bus_t out_bus;
	decode_pkg::decode_bus_t exp_q [$];
	integer seed = 32'h21fc;
	int send_cred;
	int owed;
	int n_out;
	int n_cred;
	int err_cnt;
	int pass_cnt;
	int fail_cnt;

	decode_stage u_dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_item    (in_item),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_bus    (out_bus),
		.out_credit (out_credit)
	);

	bind decode_stage decode_assertions u_chk (
		.clk       (clk),
		.rst       (rst),
		.in_credit (in_credit),
		.out_valid (out_valid),
		.out_bus   (out_bus),
		.q_count   (q_count),
		.out_cred  (out_cred)
	);

	always #50 clk = ~clk;

	// ====================
	// Reference model
	// ====================
	function automatic decode_pkg::decode_bus_t model(input decode_pkg::fetch_item_t it);
		decode_pkg::decode_bus_t b;
		logic [31:0] w;
		logic is_c;
		logic wide;
		logic bad_op;
		logic bad_reg;
		logic bad_c;
		int p;
		b = '0;
		bad_op = 1'b0;
		w = it.line[it.slot*`WORD_BITS +: `WORD_BITS];
		b.instr = w;
		is_c = (w[6:0] == isa_pkg::OP_ADDC) || (w[6:0] == isa_pkg::OP_LOADC);
		p = w[18:17];
		wide = w[19];
		b.rd = w[11:7];
		b.rs1 = w[16:12];
		// Constant form has no rs2 or rs3
		b.rs2 = is_c ? 5'd0 : w[21:17];
		b.rs3 = is_c ? 5'd0 : w[26:22];
		{b.rdz, b.rs1z, b.rs2z, b.rs3z} = {b.rd == 0, b.rs1 == 0, b.rs2 == 0, b.rs3 == 0};
		case (w[6:0])
			isa_pkg::OP_ADD, isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_ADDC:
				b.alu = 1'b1;
			isa_pkg::OP_MUL:
				b.mul = 1'b1;
			isa_pkg::OP_DIV:
				b.div = 1'b1;
			isa_pkg::OP_LOAD, isa_pkg::OP_LOADC:
				b.load = 1'b1;
			isa_pkg::OP_STORE:
				b.store = 1'b1;
			isa_pkg::OP_BEQ:
				b.branch = 1'b1;
			isa_pkg::OP_NOP:
				b.nop = 1'b1;
			default: begin
				b.nop = 1'b1;
				bad_op = 1'b1;
			end
		endcase
		b.mem = b.load | b.store;
		bad_reg = (it.mode == isa_pkg::MODE_USER) && ((b.rd >= `PRIV_REG_BASE) ||
			(b.rs1 >= `PRIV_REG_BASE) || (b.rs2 >= `PRIV_REG_BASE) || (b.rs3 >= `PRIV_REG_BASE));
		// Constant may not cover the instruction word or leave the line
		bad_c = is_c && ((p == it.slot) || (wide && ((p == 3) || (p + 1 == it.slot))));
		b.has_imm = is_c;
		if (is_c && !bad_c) begin
			b.imm[31:0] = it.line[p*`WORD_BITS +: `WORD_BITS];
			b.nop_mask[p] = 1'b1;
			if (wide) begin
				b.imm[63:32] = it.line[(p+1)*`WORD_BITS +: `WORD_BITS];
				b.nop_mask[p+1] = 1'b1;
			end
		end
		b.cause = bad_op ? decode_pkg::FLT_BADOP : bad_reg ? decode_pkg::FLT_BADREG :
			bad_c ? decode_pkg::FLT_BADCONST : decode_pkg::FLT_NONE;
		return b;
	endfunction

	// ====================
	// Stimulus helpers
	// ====================
	function automatic logic [4:0] rand_reg();
		return 5'($unsigned($random(seed)) % `PRIV_REG_BASE);
	endfunction

	function automatic logic [31:0] rword(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rs3);
		return {5'($random(seed)), rs3, rs2, rs1, rd, op};
	endfunction

	function automatic logic [31:0] cword(input logic [6:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [1:0] cpos, input logic wide);
		return {12'($random(seed)), wide, cpos, rs1, rd, op};
	endfunction

	// Other line words are random so constants differ per item
	function automatic decode_pkg::fetch_item_t make_item(input logic [31:0] w,
		input logic [1:0] slot, input isa_pkg::op_mode_t mode);
		decode_pkg::fetch_item_t it;
		it.line = {$random(seed), $random(seed), $random(seed), $random(seed)};
		it.line[slot*`WORD_BITS +: `WORD_BITS] = w;
		it.slot = slot;
		it.mode = mode;
		it.spare = 2'b00;
		return it;
	endfunction

	task automatic timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_bus(input decode_pkg::decode_bus_t e);
		check_val("instr", out_bus.instr, e.instr);
		check_val("rd/rs1/rs2/rs3", {out_bus.rd, out_bus.rs1, out_bus.rs2, out_bus.rs3},
			{e.rd, e.rs1, e.rs2, e.rs3});
		check_val("zero flags", {out_bus.rdz, out_bus.rs1z, out_bus.rs2z, out_bus.rs3z},
			{e.rdz, e.rs1z, e.rs2z, e.rs3z});
		check_val("class flags", {out_bus.alu, out_bus.mul, out_bus.div, out_bus.load,
			out_bus.store, out_bus.branch, out_bus.nop, out_bus.mem},
			{e.alu, e.mul, e.div, e.load, e.store, e.branch, e.nop, e.mem});
		check_val("has_imm", out_bus.has_imm, e.has_imm);
		check_val("imm", out_bus.imm, e.imm);
		check_val("nop_mask", out_bus.nop_mask, e.nop_mask);
		check_val("cause", out_bus.cause, e.cause);
	endtask

	// Offers one item once a credit is held and is called just after an edge
	task automatic send(input decode_pkg::fetch_item_t it);
		int t;
		t = 0;
		while (send_cred == 0) begin
			if (t++ == TIMEOUT)
				timeout("an input credit");
			@(posedge clk);
			#1;
		end
		in_item = it;
		in_valid = 1'b1;
		send_cred--;
		exp_q.push_back(model(it));
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// All expected buses seen and all their credits handed back
	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() != 0 || owed != 0) begin
			if (t++ == TIMEOUT)
				timeout("outstanding decode buses");
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	function automatic int total_errs();
		return err_cnt + u_dut.u_chk.errors;
	endfunction

	task automatic finish_test(input string name, input int errs_before);
		if (total_errs() != errs_before) begin
			fail_cnt++;
			$display("%s: FAILED", name);
		end else begin
			pass_cnt++;
			$display("%s: passed", name);
		end
	endtask

	// ====================
	// Monitor and credit return
	// ====================
	// Outputs are registered, so the edge sees last cycle's values
	always @(posedge clk) begin
		if (!rst && in_credit) begin
			send_cred++;
			n_cred++;
		end
		if (!rst && out_valid) begin
			n_out++;
			owed++;
			if (exp_q.size() == 0) begin
				$display("Decode bus arrived with no item outstanding");
				err_cnt++;
			end else
				compare_bus(exp_q.pop_front());
		end
	end

	// Rename hands back one credit per cycle unless held off
	always @(posedge clk) begin
		#1;
		if (!rst && !hold && owed > 0) begin
			out_credit = 1'b1;
			owed--;
		end else
			out_credit = 1'b0;
	end

	initial begin
		int i;
		int b0;
		int n0;
		int c0;
		logic [1:0] slot;
		logic [1:0] cpos;
		logic wide;
		decode_pkg::decode_bus_t idle;
		isa_pkg::opcode_t ops [6];
		ops = '{isa_pkg::OP_ADD, isa_pkg::OP_MUL, isa_pkg::OP_DIV,
			isa_pkg::OP_STORE, isa_pkg::OP_BEQ, isa_pkg::OP_NOP};
		rst = 1'b1;
		in_valid = 1'b0;
		in_item = '0;
		out_credit = 1'b0;
		hold = 1'b0;
		send_cred = `IN_DEPTH;
		owed = 0;
		n_out = 0;
		n_cred = 0;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle bus right after reset is a nop writing register 0
		b0 = total_errs();
		idle = '0;
		idle.nop = 1'b1;
		idle.rdz = 1'b1;
		compare_bus(idle);
		finish_test("reset state", b0);

		// Register form in random slots
		b0 = total_errs();
		for (i = 0; i < 18; i++) begin
			slot = 2'($random(seed));
			send(make_item(rword(ops[i % 6], rand_reg(), rand_reg(), rand_reg(), rand_reg()),
				slot, isa_pkg::MODE_USER));
		end
		drain();
		finish_test("register ops", b0);

		// Legal constant placements, narrow and wide
		b0 = total_errs();
		for (i = 0; i < 16; i++) begin
			slot = 2'($random(seed));
			wide = 1'($random(seed));
			do
				cpos = 2'($random(seed));
			while (cpos == slot || (wide && (cpos == 2'd3 || cpos + 2'd1 == slot)));
			send(make_item(cword(i[0] ? isa_pkg::OP_LOADC : isa_pkg::OP_ADDC, rand_reg(),
				rand_reg(), cpos, wide), slot, isa_pkg::MODE_USER));
		end
		drain();
		finish_test("constant ops", b0);

		// Privileged registers per mode, and unknown opcode priority
		b0 = total_errs();
		send(make_item(rword(isa_pkg::OP_ADD, 5'd25, 5'd1, 5'd2, 5'd3), 2'd1, isa_pkg::MODE_USER));
		send(make_item(rword(isa_pkg::OP_ADD, 5'd25, 5'd1, 5'd2, 5'd3), 2'd1, isa_pkg::MODE_SUPER));
		send(make_item(rword(isa_pkg::OP_OR, 5'd4, 5'd5, 5'd6, 5'd31), 2'd2, isa_pkg::MODE_USER));
		send(make_item(rword(7'h7f, 5'd30, 5'd1, 5'd2, 5'd3), 2'd0, isa_pkg::MODE_USER));
		send(make_item(rword(7'h40, 5'd0, 5'd0, 5'd0, 5'd0), 2'd3, isa_pkg::MODE_SUPER));
		drain();
		finish_test("register and opcode faults", b0);

		// Constant on its own slot, wide at word 3, wide onto the slot
		b0 = total_errs();
		send(make_item(cword(isa_pkg::OP_ADDC, 5'd1, 5'd2, 2'd2, 1'b0), 2'd2, isa_pkg::MODE_USER));
		send(make_item(cword(isa_pkg::OP_LOADC, 5'd3, 5'd4, 2'd3, 1'b1), 2'd0, isa_pkg::MODE_USER));
		send(make_item(cword(isa_pkg::OP_ADDC, 5'd5, 5'd6, 2'd1, 1'b1), 2'd2, isa_pkg::MODE_USER));
		drain();
		finish_test("constant faults", b0);

		// Back-pressure with output credits withheld
		b0 = total_errs();
		n0 = n_out;
		c0 = n_cred;
		hold = 1'b1;
		for (i = 0; i < OP_OUT_CREDITS + `IN_DEPTH; i++)
			send(make_item(rword(ops[i % 6], rand_reg(), rand_reg(), rand_reg(), rand_reg()),
				2'($random(seed)), isa_pkg::MODE_USER));
		i = 0;
		while (n_out - n0 < OP_OUT_CREDITS) begin
			if (i++ == TIMEOUT)
				timeout("decode buses under back-pressure");
			@(posedge clk);
			#1;
		end
		// Let the stage settle while nothing more may leave
		repeat (4) @(posedge clk);
		#1;
		check_val("out_valid count", n_out - n0, OP_OUT_CREDITS);
		check_val("sender credits", send_cred, 0);
		hold = 1'b0;
		drain();
		check_val("decoded count", n_out - n0, OP_OUT_CREDITS + `IN_DEPTH);
		check_val("in_credit count", n_cred - c0, OP_OUT_CREDITS + `IN_DEPTH);
		finish_test("back-pressure", b0);

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && total_errs() == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
source/isa_pkg.sv
source/decode_pkg.sv
source/decode_const.sv
source/decode_regs.sv
source/decode_class.sv
source/instr_decoder.sv
source/decode_stage.sv
tb/decode_assertions.sv
tb/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - files:
      - source/isa_pkg.sv
      - source/decode_pkg.sv
      - source/decode_const.sv
      - source/decode_regs.sv
      - source/decode_class.sv
      - source/instr_decoder.sv
      - source/decode_stage.sv
  - target: test
    files:
      - tb/decode_assertions.sv
      - tb/tb_decode_stage.sv
